//--- mulDivCmdPkg.sv
package mulDivCmdPkg;

	// one word, the operand width of the 32-bit ops on a 64-bit core
	// modules narrower than 64 bits use half their own width instead
	localparam int halfWidth = 32;

	// opcode bundle for the slow multiply/divide unit
	// all three flags clear means a signed 64-bit multiply
	typedef struct packed {
		// divide instead of multiply
		logic isDiv;
		// operands are unsigned, no sign fixup
		logic isUnsigned;
		// low word only, results extended from it
		logic isHalf;
	} mdCmd;

endpackage

//--- mulDivDataPkg.sv
package mulDivDataPkg;

	// sequencer phases
	// load clears the core, iterate runs one bit per clock,
	// fixup applies signs and extension to the raw magnitudes
	typedef enum logic [1:0] {
		phaseIdle    = 2'd0,
		phaseLoad    = 2'd1,
		phaseIterate = 2'd2,
		phaseFixup   = 2'd3
	} mdPhase;

	// sign handling for the final results
	typedef struct packed {
		// negate the low result (quotient, or the whole product)
		logic negLo;
		// negate the high result (remainder)
		logic negHi;
		// extend from the half word
		logic isHalf;
		// zero extension instead of sign extension
		logic isUnsigned;
	} mdSignInfo;

endpackage

//--- mulDivControl.sv
module mulDivControl #(
	parameter int dataWidth = 64
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  mulDivCmdPkg::mdCmd     cmd,
	output mulDivDataPkg::mdPhase  phase,
	output logic                   loadOperands,
	output logic                   halfMode,
	output logic                   isDiv,
	output logic                   busy,
	output logic                   done
);
	import mulDivCmdPkg::*;
	import mulDivDataPkg::*;

	// half-mode operand width, one word on the 64-bit core
	localparam int halfBits = (dataWidth == 2 * halfWidth) ? halfWidth : dataWidth / 2;
	localparam int cntWidth = $clog2(dataWidth + 1);

	// command latched at start, held for the whole operation
	mdCmd cmdReg;
	// remaining iterate cycles
	logic [cntWidth-1:0] count;

	// start only counts while idle, a start while busy is dropped
	assign loadOperands = start && (phase == phaseIdle);
	assign busy = (phase != phaseIdle);
	assign halfMode = cmdReg.isHalf;
	assign isDiv = cmdReg.isDiv;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			phase <= phaseIdle;
			count <= '0;
			cmdReg <= '0;
			done <= 1'b0;
		end
		else
		begin
			// done is a single-cycle pulse
			done <= 1'b0;
			case (phase)
				phaseIdle:
				begin
					if (start)
					begin
						phase <= phaseLoad;
						cmdReg <= cmd;
						// one iterate cycle per operand bit
						count <= cmd.isHalf ? cntWidth'(halfBits) : cntWidth'(dataWidth);
					end
				end
				phaseLoad:
				begin
					phase <= phaseIterate;
				end
				phaseIterate:
				begin
					count <= count - 1'b1;
					// last bit goes in on this edge
					if (count == cntWidth'(1))
						phase <= phaseFixup;
				end
				phaseFixup:
				begin
					// results register on this same edge
					phase <= phaseIdle;
					done <= 1'b1;
				end
				default:
				begin
					phase <= phaseIdle;
				end
			endcase
		end
	end

endmodule

//--- mulDivOperandPrep.sv
module mulDivOperandPrep #(
	parameter int dataWidth = 64
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      loadOperands,
	input  mulDivCmdPkg::mdCmd        cmd,
	input  logic [dataWidth-1:0]      opA,
	input  logic [dataWidth-1:0]      opB,
	output logic [dataWidth-1:0]      magA,
	output logic [dataWidth-1:0]      magB,
	output logic [dataWidth-1:0]      addB,
	output mulDivDataPkg::mdSignInfo  signInfo
);
	import mulDivCmdPkg::*;

	localparam int halfBits = (dataWidth == 2 * halfWidth) ? halfWidth : dataWidth / 2;

	logic signA;
	logic signB;
	logic [halfBits-1:0] halfMagA;
	logic [halfBits-1:0] halfMagB;
	logic [dataWidth-1:0] nextMagA;
	logic [dataWidth-1:0] nextMagB;

	always_comb
	begin
		// sign from the top of the word in use
		signA = cmd.isHalf ? opA[halfBits-1] : opA[dataWidth-1];
		signB = cmd.isHalf ? opB[halfBits-1] : opB[dataWidth-1];
		if (cmd.isUnsigned)
		begin
			signA = 1'b0;
			signB = 1'b0;
		end
		// half mode ignores the upper operand bits entirely
		halfMagA = signA ? -opA[halfBits-1:0] : opA[halfBits-1:0];
		halfMagB = signB ? -opB[halfBits-1:0] : opB[halfBits-1:0];
		if (cmd.isHalf)
		begin
			// A sits in the upper half so its msb is the first bit shifted out
			nextMagA = {halfMagA, {halfBits{1'b0}}};
			nextMagB = {{halfBits{1'b0}}, halfMagB};
		end
		else
		begin
			nextMagA = signA ? -opA : opA;
			nextMagB = signB ? -opB : opB;
		end
	end

	always_ff @(posedge clock)
	begin
		if (loadOperands)
		begin
			magA <= nextMagA;
			magB <= nextMagB;
			// subtrahend for the restoring divide
			addB <= -nextMagB;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			signInfo <= '0;
		else if (loadOperands)
		begin
			signInfo.negLo <= signA ^ signB;
			// remainder follows the dividend, product halves share one sign
			signInfo.negHi <= cmd.isDiv ? signA : (signA ^ signB);
			signInfo.isHalf <= cmd.isHalf;
			signInfo.isUnsigned <= cmd.isUnsigned;
		end
	end

endmodule

//--- mulDivShiftCore.sv
module mulDivShiftCore #(
	parameter int dataWidth = 64
) (
	input  logic                   clock,
	input  logic                   reset,
	input  mulDivDataPkg::mdPhase  phase,
	input  logic                   isDiv,
	input  logic [dataWidth-1:0]   magA,
	input  logic [dataWidth-1:0]   magB,
	input  logic [dataWidth-1:0]   addB,
	output logic [dataWidth-1:0]   accHi,
	output logic [dataWidth-1:0]   accLo
);
	import mulDivDataPkg::*;

	// acc is the accumulator, shf the shifter loaded with magA
	logic [dataWidth-1:0] acc;
	logic [dataWidth-1:0] shf;

	logic [2*dataWidth-1:0] mulShift;
	logic [2*dataWidth-1:0] mulSum;
	logic [dataWidth-1:0] remLow;
	logic [dataWidth-1:0] remDiff;
	logic remCarry;
	logic remTop;
	logic divKeep;

	always_comb
	begin
		// multiply, msb first
		// shf = {multiplier bits left, product high bits}, acc = product low bits
		// the product never carries into the remaining multiplier bits
		mulShift = {shf, acc} << 1;
		mulSum = mulShift + (shf[dataWidth-1] ? {{dataWidth{1'b0}}, magB} : '0);

		// restoring divide
		// pair is {acc, shf}, next dividend bit comes off the top of shf
		remTop = acc[dataWidth-1];
		remLow = {acc[dataWidth-2:0], shf[dataWidth-1]};
		{remCarry, remDiff} = {1'b0, remLow} + {1'b0, addB};
		// no borrow when the shifted remainder overflowed one word,
		// or the subtract carried out
		// a zero divisor always keeps, giving all-ones quotient
		divKeep = remTop | remCarry | (addB == '0);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			acc <= '0;
			shf <= '0;
		end
		else if (phase == phaseLoad)
		begin
			acc <= '0;
			shf <= magA;
		end
		else if (phase == phaseIterate)
		begin
			if (isDiv)
			begin
				acc <= divKeep ? remDiff : remLow;
				// quotient bits enter from the bottom
				shf <= {shf[dataWidth-2:0], divKeep};
			end
			else
			begin
				{shf, acc} <= mulSum;
			end
		end
	end

	// divide leaves remainder in acc and quotient in shf,
	// multiply leaves the high product in shf
	assign accHi = isDiv ? acc : shf;
	assign accLo = isDiv ? shf : acc;

endmodule

//--- mulDivResultFix.sv
module mulDivResultFix #(
	parameter int dataWidth = 64
) (
	input  logic                      clock,
	input  logic                      reset,
	input  mulDivDataPkg::mdPhase     phase,
	input  logic                      isDiv,
	input  mulDivDataPkg::mdSignInfo  signInfo,
	input  logic [dataWidth-1:0]      accHi,
	input  logic [dataWidth-1:0]      accLo,
	output logic [dataWidth-1:0]      resultLo,
	output logic [dataWidth-1:0]      resultHi
);
	import mulDivCmdPkg::*;
	import mulDivDataPkg::*;

	localparam int halfBits = (dataWidth == 2 * halfWidth) ? halfWidth : dataWidth / 2;

	logic [2*dataWidth-1:0] prodFixed;
	logic [dataWidth-1:0] loFixed;
	logic [dataWidth-1:0] hiFixed;
	logic [dataWidth-1:0] nextLo;
	logic [dataWidth-1:0] nextHi;
	logic loExt;
	logic hiExt;

	always_comb
	begin
		// full multiply negates both halves as one value
		prodFixed = signInfo.negLo ? -{accHi, accLo} : {accHi, accLo};
		// quotient and remainder, or the half product, one word each
		loFixed = signInfo.negLo ? -accLo : accLo;
		hiFixed = signInfo.negHi ? -accHi : accHi;
		loExt = ~signInfo.isUnsigned & loFixed[halfBits-1];
		hiExt = ~signInfo.isUnsigned & hiFixed[halfBits-1];
		if (isDiv && signInfo.isHalf)
		begin
			nextLo = {{halfBits{loExt}}, loFixed[halfBits-1:0]};
			nextHi = {{halfBits{hiExt}}, hiFixed[halfBits-1:0]};
		end
		else if (isDiv)
		begin
			nextLo = loFixed;
			nextHi = hiFixed;
		end
		else if (signInfo.isHalf)
		begin
			// whole half product fits in the low word, high word is its sign
			nextLo = loFixed;
			nextHi = {dataWidth{~signInfo.isUnsigned & loFixed[dataWidth-1]}};
		end
		else
		begin
			{nextHi, nextLo} = prodFixed;
		end
	end

	// results hold until the next operation finishes
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			resultLo <= '0;
			resultHi <= '0;
		end
		else if (phase == phaseFixup)
		begin
			resultLo <= nextLo;
			resultHi <= nextHi;
		end
	end

endmodule

//--- slowMulDiv.sv
module slowMulDiv #(
	parameter int dataWidth = 64
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	input  mulDivCmdPkg::mdCmd    cmd,
	input  logic [dataWidth-1:0]  opA,
	input  logic [dataWidth-1:0]  opB,
	output logic                  busy,
	output logic                  done,
	output logic [dataWidth-1:0]  resultLo,
	output logic [dataWidth-1:0]  resultHi
);
	import mulDivDataPkg::*;

	mdPhase phase;
	mdSignInfo signInfo;
	logic loadOperands;
	// latched opcode flag, valid from load through fixup
	logic isDiv;
	logic [dataWidth-1:0] magA;
	logic [dataWidth-1:0] magB;
	logic [dataWidth-1:0] addB;
	logic [dataWidth-1:0] accHi;
	logic [dataWidth-1:0] accLo;

	// sequencer
	mulDivControl #(
		.dataWidth(dataWidth)
	) control_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.cmd(cmd),
		.phase(phase),
		.loadOperands(loadOperands),
		.halfMode(),
		.isDiv(isDiv),
		.busy(busy),
		.done(done)
	);

	mulDivOperandPrep #(
		.dataWidth(dataWidth)
	) operandPrep_i (
		.clock(clock),
		.reset(reset),
		.loadOperands(loadOperands),
		.cmd(cmd),
		.opA(opA),
		.opB(opB),
		.magA(magA),
		.magB(magB),
		.addB(addB),
		.signInfo(signInfo)
	);

	// one bit per clock on unsigned magnitudes
	mulDivShiftCore #(
		.dataWidth(dataWidth)
	) shiftCore_i (
		.clock(clock),
		.reset(reset),
		.phase(phase),
		.isDiv(isDiv),
		.magA(magA),
		.magB(magB),
		.addB(addB),
		.accHi(accHi),
		.accLo(accLo)
	);

	mulDivResultFix #(
		.dataWidth(dataWidth)
	) resultFix_i (
		.clock(clock),
		.reset(reset),
		.phase(phase),
		.isDiv(isDiv),
		.signInfo(signInfo),
		.accHi(accHi),
		.accLo(accLo),
		.resultLo(resultLo),
		.resultHi(resultHi)
	);

endmodule

//--- slowMulDivChecker.sv
module slowMulDivChecker #(
	parameter int dataWidth = 64
) (
	input logic                  clock,
	input logic                  reset,
	input logic                  start,
	input mulDivCmdPkg::mdCmd    cmd,
	input logic                  busy,
	input logic                  done,
	input logic [dataWidth-1:0]  resultLo,
	input logic [dataWidth-1:0]  resultHi
);
	import mulDivCmdPkg::*;

	int passCount = 0;
	int failCount = 0;
	// failures outside any operation, e.g. a stray done
	int otherErrors = 0;

	// operation in flight
	logic active = 1'b0;
	int testErrors = 0;
	int elapsed = 0;
	// start to done in cycles, N+2
	int latency = 0;
	logic inReset = 1'b0;
	// results of the last done, held until the next one
	logic [dataWidth-1:0] heldLo = '0;
	logic [dataWidth-1:0] heldHi = '0;

	task automatic reportFailure(input string what);
		$display("error at time %0t: %s", $time, what);
		if (active)
			testErrors++;
		else
			otherErrors++;
	endtask

	task automatic checkWord(input string name, input logic [dataWidth-1:0] expected,
		input logic [dataWidth-1:0] actual);
		if (actual !== expected)
		begin
			$display("mismatch at time %0t: %s expected %h, got %h",
				$time, name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic endTest();
		if (testErrors == 0)
		begin
			passCount++;
			$display("test %0d passed", slowMulDivTb.testIndex);
		end
		else
		begin
			failCount++;
			$display("test %0d failed with %0d errors", slowMulDivTb.testIndex, testErrors);
		end
		active = 1'b0;
	endtask

	// sampled on the same edge the DUT sees, before its outputs update
	always @(posedge clock)
	begin
		if (reset === 1'b1)
		begin
			inReset = 1'b1;
			active = 1'b0;
		end
		else
		begin
			if (inReset)
			begin
				// first edge out of reset shows the reset values
				inReset = 1'b0;
				if (busy !== 1'b0 || done !== 1'b0)
					reportFailure("busy or done not low after reset");
				if (resultLo !== '0 || resultHi !== '0)
					reportFailure("results not zero after reset");
				heldLo = resultLo;
				heldHi = resultHi;
			end
			if (done !== 1'b1 && (resultLo !== heldLo || resultHi !== heldHi))
			begin
				reportFailure("results changed without a done pulse");
				heldLo = resultLo;
				heldHi = resultHi;
			end
			if (active)
			begin
				elapsed++;
				if (done === 1'b1)
				begin
					// done seen one edge after it was set
					if (elapsed - 1 != latency)
						reportFailure($sformatf("done came %0d cycles after start, expected %0d",
							elapsed - 1, latency));
					if (busy !== 1'b0)
						reportFailure("busy still high in the done cycle");
					checkWord("resultLo", slowMulDivTb.expLo, resultLo);
					checkWord("resultHi", slowMulDivTb.expHi, resultHi);
					endTest();
				end
				else if (busy !== 1'b1)
				begin
					reportFailure("busy dropped before done");
					endTest();
				end
				else if (elapsed > latency + 1)
				begin
					reportFailure("done did not arrive in time");
					endTest();
				end
			end
			else if (done === 1'b1)
				reportFailure("done pulse with no operation in flight");
			if (done === 1'b1)
			begin
				heldLo = resultLo;
				heldHi = resultHi;
			end
			// starts while busy are dropped by the DUT, only idle ones count
			if (!active && start === 1'b1 && busy === 1'b0)
			begin
				active = 1'b1;
				testErrors = 0;
				elapsed = 0;
				latency = (cmd.isHalf ? halfWidth : dataWidth) + 2;
			end
		end
	end

endmodule

//--- slowMulDivTb.sv
module slowMulDivTb;
	import mulDivCmdPkg::*;

	localparam int dataWidth = 64;
	// longest operation plus the largest idle gap
	localparam int cyclesPerTest = 66 + 8;

	logic clock;
	logic reset;
	logic start;
	mdCmd cmd;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic busy;
	logic done;
	logic [dataWidth-1:0] resultLo;
	logic [dataWidth-1:0] resultHi;

	// current test, the checker reads these
	int testIndex;
	logic [dataWidth-1:0] expLo;
	logic [dataWidth-1:0] expHi;

	// whole data file, one entry per test
	mdCmd testCmd[$];
	logic [dataWidth-1:0] testA[$];
	logic [dataWidth-1:0] testB[$];
	logic [dataWidth-1:0] testLo[$];
	logic [dataWidth-1:0] testHi[$];
	logic [31:0] lcgState;
	logic loaded = 1'b0;

	slowMulDiv #(
		.dataWidth(dataWidth)
	) dut_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.cmd(cmd),
		.opA(opA),
		.opB(opB),
		.busy(busy),
		.done(done),
		.resultLo(resultLo),
		.resultHi(resultHi)
	);

	slowMulDivChecker #(
		.dataWidth(dataWidth)
	) scoreboard_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.cmd(cmd),
		.busy(busy),
		.done(done),
		.resultLo(resultLo),
		.resultHi(resultHi)
	);

	always #2 clock = ~clock;

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic readTests(output logic opened);
		int fd;
		int fields;
		logic [8*200-1:0] lineBuf;
		logic [3:0] flagDiv;
		logic [3:0] flagUns;
		logic [3:0] flagHalf;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] lo;
		logic [dataWidth-1:0] hi;
		fd = $fopen("slowMulDivTestdata.txt", "r");
		opened = (fd != 0);
		if (opened)
		begin
			lineBuf = '0;
			while ($fgets(lineBuf, fd) != 0)
			begin
				// comment and blank lines do not parse
				fields = $sscanf(lineBuf, "%h %h %h %h %h %h %h",
					flagDiv, flagUns, flagHalf, a, b, lo, hi);
				if (fields == 7)
				begin
					testCmd.push_back(mdCmd'({flagDiv[0], flagUns[0], flagHalf[0]}));
					testA.push_back(a);
					testB.push_back(b);
					testLo.push_back(lo);
					testHi.push_back(hi);
				end
				lineBuf = '0;
			end
			$fclose(fd);
		end
	endtask

	task automatic runTest(input int idx);
		int gap;
		int extraDelay;
		lcgState = nextRandom(lcgState);
		gap = lcgState[18:16];
		extraDelay = 1 + lcgState[25:24];
		repeat (gap) @(posedge clock);
		start <= 1'b1;
		cmd <= testCmd[idx];
		opA <= testA[idx];
		opB <= testB[idx];
		expLo <= testLo[idx];
		expHi <= testHi[idx];
		testIndex <= idx + 1;
		@(posedge clock);
		start <= 1'b0;
		// second start while busy with other operands, must be dropped
		repeat (extraDelay) @(posedge clock);
		start <= 1'b1;
		cmd <= mdCmd'(~testCmd[idx]);
		opA <= ~testA[idx];
		opB <= testB[idx] ^ 64'h5a5a_a5a5_0ff0_f00f;
		@(posedge clock);
		start <= 1'b0;
		do
			@(posedge clock);
		while (done !== 1'b1);
	endtask

	initial
	begin
		int i;
		logic fileOk;
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		cmd = '0;
		opA = '0;
		opB = '0;
		expLo = '0;
		expHi = '0;
		testIndex = 0;
		lcgState = 32'h46a;
		readTests(fileOk);
		if (!fileOk)
		begin
			$display("error: cannot open the test data file");
			$display("Simulation FAILED");
			$finish;
		end
		else
		begin
			loaded = 1'b1;
			repeat (16) @(posedge clock);
			reset <= 1'b0;
			for (i = 0; i < testCmd.size(); i++)
				runTest(i);
			// let the checker finish the last edge
			repeat (2) @(posedge clock);
			$display("tests %0d, passed %0d, failed %0d, other errors %0d",
				testCmd.size(), scoreboard_i.passCount, scoreboard_i.failCount,
				scoreboard_i.otherErrors);
			if (testCmd.size() > 0 && scoreboard_i.passCount == testCmd.size()
				&& scoreboard_i.failCount == 0 && scoreboard_i.otherErrors == 0)
				$display("Simulation PASSED");
			else
				$display("Simulation FAILED");
			$finish;
		end
	end

	// watchdog, sized from the number of tests
	initial
	begin
		wait (loaded);
		repeat (testCmd.size() * cyclesPerTest + 100) @(posedge clock);
		$display("error: timeout, the DUT never finished test %0d", testIndex);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- list.f
mulDivCmdPkg.sv
mulDivDataPkg.sv
mulDivControl.sv
mulDivOperandPrep.sv
mulDivShiftCore.sv
mulDivResultFix.sv
slowMulDiv.sv
slowMulDivChecker.sv
slowMulDivTb.sv

//--- Bender.yml
package:
  name: slow_mul_div

sources:
  - mulDivCmdPkg.sv
  - mulDivDataPkg.sv
  - mulDivControl.sv
  - mulDivOperandPrep.sv
  - mulDivShiftCore.sv
  - mulDivResultFix.sv
  - slowMulDiv.sv
  - target: test
    files:
      - slowMulDivChecker.sv
      - slowMulDivTb.sv

//--- slowMulDivTestdata.txt
# isDiv isUnsigned isHalf opA opB expLo expHi, all hex
# expLo/expHi hold product low/high, or quotient/remainder
0 1 0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000001 FFFFFFFFFFFFFFFE
0 1 0 0000000100000000 0000000100000000 0000000000000000 0000000000000001
0 1 0 8000000000000000 0000000000000003 8000000000000000 0000000000000001
1 1 0 FFFFFFFFFFFFFFFF 0000000000000010 0FFFFFFFFFFFFFFF 000000000000000F
1 1 0 FFFFFFFFFFFFFFFF 8000000000000000 0000000000000001 7FFFFFFFFFFFFFFF
1 1 0 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000 8000000000000000
0 0 0 FFFFFFFFFFFFFFFE 0000000000000003 FFFFFFFFFFFFFFFA FFFFFFFFFFFFFFFF
0 0 0 0000000000000007 FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFF2 FFFFFFFFFFFFFFFF
0 0 0 7FFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF 0000000000000001 3FFFFFFFFFFFFFFF
0 0 0 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000 0000000000000000
1 0 0 0000000000000064 0000000000000007 000000000000000E 0000000000000002
1 0 0 FFFFFFFFFFFFFF9C 0000000000000007 FFFFFFFFFFFFFFF2 FFFFFFFFFFFFFFFE
1 0 0 0000000000000064 FFFFFFFFFFFFFFF9 FFFFFFFFFFFFFFF2 0000000000000002
1 0 0 FFFFFFFFFFFFFF9C FFFFFFFFFFFFFFF9 000000000000000E FFFFFFFFFFFFFFFE
1 0 0 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000 0000000000000000
1 1 0 123456789ABCDEF0 0000000000000000 FFFFFFFFFFFFFFFF 123456789ABCDEF0
0 0 1 ABCDEF01FFFFFFFE 1234567800000003 FFFFFFFFFFFFFFFA FFFFFFFFFFFFFFFF
0 1 1 FFFFFFFFFFFFFFFF 55555555FFFFFFFF FFFFFFFE00000001 0000000000000000
0 0 1 9999999980000000 0000000080000000 4000000000000000 0000000000000000
0 0 1 FEDCBA987FFFFFFF 0000000080000000 C000000080000000 FFFFFFFFFFFFFFFF
1 0 1 77777777FFFFFF9C 1111111100000007 FFFFFFFFFFFFFFF2 FFFFFFFFFFFFFFFE
1 1 1 AAAAAAAAFFFFFFFF BBBBBBBB00000010 000000000FFFFFFF 000000000000000F
1 0 1 0000000080000000 00000000FFFFFFFF FFFFFFFF80000000 0000000000000000
1 1 1 DEADBEEF00000007 0000000000000000 00000000FFFFFFFF 0000000000000007
